// ==== cpu_frontend.f ====
+incdir+common
+incdir+tb
common/frontend_pkg.sv
fetch/inst_sram.sv
fetch/if_stage.sv
verilog/id_stage.sv
verilog/cpu_frontend.sv
tb/tb_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module tb_frontend -f cpu_frontend.f

out=$(./obj_dir/Vtb_frontend)
printf '%s\n' "$out"

# Non-zero exit when the pass line is missing
printf '%s\n' "$out" | grep -qx "Simulation completed successfully"

// ==== tb/frontend_ref.svh ====
`ifndef FRONTEND_REF_SVH
`define FRONTEND_REF_SVH

////////////////////////////////////////////////////////////
// Reference model and program generator
////////////////////////////////////////////////////////////

// Branch opcodes, I26 format
localparam logic [5:0] OPC_B  = 6'b010100;
localparam logic [5:0] OPC_BL = 6'b010101;

// 13/17/5 shift triple
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// Random word that is never B or BL
function automatic logic [31:0] filler_word(input logic [31:0] r);
    logic [31:0] w;
    w = r;
    // Both branch opcodes share the top five bits 01010
    if (w[31:27] == 5'b01010) begin
        w[31] = 1'b1;
    end
    return w;
endfunction

// I26 encoding, offset in words, low 16 bits sit above the high 10
function automatic logic [31:0] branch_word(input logic [5:0] op, input int from_idx,
                                            input int to_idx);
    logic [25:0] offs;
    offs = 26'(to_idx - from_idx);
    return {op, offs[15:0], offs[25:16]};
endfunction

// Next PC after a word, target for B and BL, else sequential
function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] word);
    logic [25:0] offs;
    offs = {word[9:0], word[25:10]};
    if (word[31:26] == OPC_B || word[31:26] == OPC_BL) begin
        return pc + {{4{offs[25]}}, offs, 2'b00};
    end
    return pc + 32'd4;
endfunction

// Decode output expected for the word at pc
function automatic id_to_ex_t expected_bus(input logic [31:0] pc);
    id_to_ex_t   e;
    logic [31:0] w;
    w           = prog[pc[`INST_SRAM_AW+1:2]];
    e.pc        = pc;
    e.inst      = w;
    e.is_branch = (w[31:26] == OPC_B) || (w[31:26] == OPC_BL);
    e.rd        = w[4:0];
    return e;
endfunction

// Random fill plus a fixed branch skeleton
// Path 0..10, 100..108, 40..50, 200..206, 60..70, then 70 spins on itself
task automatic build_program();
    int i;
    for (i = 0; i < `INST_SRAM_DEPTH; i++) begin
        gen_state = xorshift32(gen_state);
        prog[i]   = filler_word(gen_state);
    end
    prog[10]  = branch_word(OPC_B, 10, 100);
    prog[108] = branch_word(OPC_BL, 108, 40);
    prog[50]  = branch_word(OPC_BL, 50, 200);
    prog[206] = branch_word(OPC_B, 206, 60);
    // Self loop, offset zero
    prog[70]  = branch_word(OPC_B, 70, 70);
endtask

`endif

// ==== tb/tb_frontend.sv ====
`timescale 1ns/10ps
`include "frontend_defs.svh"

module tb_frontend;

    import frontend_pkg::*;

    // Skeleton reaches the self loop after 49 transfers
    localparam int N_XFER          = 64;
    // Two loads with reset tail, four cycles per transfer, some slack
    localparam int WATCHDOG_CYCLES = 2 * (`INST_SRAM_DEPTH + 10) + 2 * N_XFER * 4 + 100;

    logic        clk = 1'b0;
    logic        resetn;
    load_req_t   load;
    logic        ex_allowin = 1'b1;
    logic        id_to_ex_valid;
    id_to_ex_t   id_to_ex;

    // Memory image and random streams
    logic [31:0] prog [0:`INST_SRAM_DEPTH-1];
    logic [31:0] gen_state   = 32'h104;
    logic [31:0] stall_state = 32'h104;
    logic        stall_mode  = 1'b0;

    // Comparison state
    string       phase_name;
    logic [31:0] exp_pc;
    int          xfer_count     = 0;
    int          n_checks       = 0;
    int          n_errors       = 0;
    int          since_reset    = 0;
    logic        prev_reset_low = 1'b0;
    logic        hold_pending   = 1'b0;
    id_to_ex_t   held_bus;

    `include "frontend_ref.svh"

    cpu_frontend uut (
        .clk            (clk),
        .resetn         (resetn),
        .load           (load),
        .ex_allowin     (ex_allowin),
        .id_to_ex_valid (id_to_ex_valid),
        .id_to_ex       (id_to_ex)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Check tasks
    ////////////////////////////////////////////////////////////

    // Fields printed as pc/inst/is_branch/rd
    task automatic check_bus(input string name, input id_to_ex_t exp_bus,
                             input id_to_ex_t act_bus);
        n_checks++;
        if (exp_bus !== act_bus) begin
            n_errors++;
            $display("FAILED %s: expected %h/%h/%b/%0d actual %h/%h/%b/%0d", name,
                     exp_bus.pc, exp_bus.inst, exp_bus.is_branch, exp_bus.rd,
                     act_bus.pc, act_bus.inst, act_bus.is_branch, act_bus.rd);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
        n_checks++;
        if (exp_bit !== act_bit) begin
            n_errors++;
            $display("FAILED %s: expected %b actual %b", name, exp_bit, act_bit);
        end
    endtask

    // Reset stays low through the load and 8 quiet cycles after it
    task automatic reload_program(input string name, input logic stall);
        int i;
        @(posedge clk);
        #1;
        resetn     = 1'b0;
        phase_name = name;
        stall_mode = stall;
        build_program();
        for (i = 0; i < `INST_SRAM_DEPTH; i++) begin
            @(posedge clk);
            #1;
            load.en   = 1'b1;
            load.addr = i[`INST_SRAM_AW-1:0];
            load.data = prog[i];
        end
        @(posedge clk);
        #1;
        load = '0;
        repeat (8) @(posedge clk);
        #1;
        resetn     = 1'b1;
        xfer_count = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Back-pressure, about one cycle in four held
    always @(posedge clk) begin
        #1;
        if (stall_mode) begin
            stall_state = xorshift32(stall_state);
            ex_allowin  = (stall_state[1:0] != 2'b00);
        end else begin
            ex_allowin = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Comparison, mid cycle where everything is settled
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!resetn) begin
            // Registers only clear after an edge seen in reset
            if (prev_reset_low) begin
                check_bit({phase_name, " valid in reset"}, 1'b0, id_to_ex_valid);
            end
            exp_pc       = `BOOT_PC;
            hold_pending = 1'b0;
            since_reset  = 0;
        end else begin
            // First word spends one cycle in fetch and one in decode
            if (since_reset < 3) begin
                since_reset++;
                check_bit({phase_name, " valid after reset"}, since_reset == 3,
                          id_to_ex_valid);
            end
            // Stalled word must sit unchanged
            if (hold_pending) begin
                check_bit({phase_name, " hold valid"}, 1'b1, id_to_ex_valid);
                check_bus({phase_name, " hold bus"}, held_bus, id_to_ex);
            end
            // Transfer happens at the coming edge
            if (id_to_ex_valid && ex_allowin) begin
                check_bus({phase_name, " transfer"}, expected_bus(exp_pc), id_to_ex);
                exp_pc = next_pc(exp_pc, prog[exp_pc[`INST_SRAM_AW+1:2]]);
                xfer_count++;
            end
            hold_pending = id_to_ex_valid & ~ex_allowin;
            held_bus     = id_to_ex;
        end
        prev_reset_low = ~resetn;
    end

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        resetn     = 1'b0;
        load       = '0;
        phase_name = "straight_run";
        reload_program("straight_run", 1'b0);
        wait (xfer_count >= N_XFER);
        // Fresh program, random stalls
        reload_program("stalled_run", 1'b1);
        wait (xfer_count >= N_XFER);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("Run timed out after %0d cycles before all transfers arrived",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog/cpu_frontend.sv ====
`timescale 1ns/10ps
`include "frontend_defs.svh"

module cpu_frontend (
    input  logic                    clk,
    input  logic                    resetn,
    // Program load port
    input  frontend_pkg::load_req_t load,
    // Downstream handshake
    input  logic                    ex_allowin,
    output logic                    id_to_ex_valid,
    output frontend_pkg::id_to_ex_t id_to_ex
);

    import frontend_pkg::*;

    // Fetch and SRAM
    logic                     inst_sram_en;
    logic [31:0]              inst_sram_addr;
    logic [31:0]              inst_sram_rdata;
    logic [`INST_SRAM_AW-1:0] inst_sram_index;

    // Fetch and decode
    logic                     if_to_id_valid;
    if_to_id_t                if_to_id;
    logic                     id_allowin;
    logic                     br_taken;
    logic [31:0]              br_target;

    // Byte address to word index
    assign inst_sram_index = inst_sram_addr[`INST_SRAM_AW+1:2];

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    if_stage u_if_stage (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .id_allowin      (id_allowin),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .if_to_id_valid  (if_to_id_valid),
        .if_to_id        (if_to_id)
    );

    inst_sram u_inst_sram (
        .clk   (clk),
        .en    (inst_sram_en),
        .addr  (inst_sram_index),
        .rdata (inst_sram_rdata),
        .load  (load)
    );

    id_stage u_id_stage (
        .clk            (clk),
        .resetn         (resetn),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id       (if_to_id),
        .id_allowin     (id_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .ex_allowin     (ex_allowin),
        .id_to_ex_valid (id_to_ex_valid),
        .id_to_ex       (id_to_ex)
    );

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/10ps

module id_stage (
    input  logic                    clk,
    input  logic                    resetn,
    // From fetch
    input  logic                    if_to_id_valid,
    input  frontend_pkg::if_to_id_t if_to_id,
    output logic                    id_allowin,
    // Redirect back to fetch
    output logic                    br_taken,
    output logic [31:0]             br_target,
    // To downstream stage
    input  logic                    ex_allowin,
    output logic                    id_to_ex_valid,
    output frontend_pkg::id_to_ex_t id_to_ex
);

    import frontend_pkg::*;

    logic        id_valid;
    logic        id_dead;
    logic [31:0] id_pc;
    inst_word_u  id_inst;
    logic        id_is_branch;
    logic [31:0] br_offs;

    ////////////////////////////////////////////////////////////
    // Handshake and valid bits
    ////////////////////////////////////////////////////////////

    // Dead word never shows as valid
    assign id_to_ex_valid = id_valid & ~id_dead;
    // Empty or dead slot always accepts
    assign id_allowin     = ~id_to_ex_valid | ex_allowin;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            id_valid <= 1'b0;
            id_dead  <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid;
            // Word captured as a branch leaves is the wrong-path one
            // Next accepted word clears the flag again
            id_dead  <= br_taken;
        end
    end

    // Payload only moves with a real transfer
    always_ff @(posedge clk) begin
        if (id_allowin & if_to_id_valid) begin
            id_pc   <= if_to_id.pc;
            id_inst <= if_to_id.inst;
        end
    end

    ////////////////////////////////////////////////////////////
    // Branch resolve
    ////////////////////////////////////////////////////////////

    // B and BL share the I26 opcode position
    assign id_is_branch = (id_inst.fmt_i26.opcode == OP_B) |
                          (id_inst.fmt_i26.opcode == OP_BL);

    // offs[25:16] sits in the low field, sign from its top bit
    assign br_offs = {{4{id_inst.fmt_i26.offs_hi[9]}},
                      id_inst.fmt_i26.offs_hi,
                      id_inst.fmt_i26.offs_lo,
                      2'b00};

    assign br_target = id_pc + br_offs;
    // One cycle strobe, only as the branch actually leaves
    assign br_taken  = id_to_ex_valid & id_is_branch & ex_allowin;

    ////////////////////////////////////////////////////////////
    // Downstream bus
    ////////////////////////////////////////////////////////////

    always_comb begin
        id_to_ex.pc        = id_pc;
        id_to_ex.inst      = id_inst;
        id_to_ex.is_branch = id_is_branch;
        // rd read through the 2RI12 view
        id_to_ex.rd        = id_inst.fmt_2ri12.rd;
    end

endmodule

// ==== fetch/if_stage.sv ====
`timescale 1ns/10ps
`include "frontend_defs.svh"

module if_stage (
    input  logic                    clk,
    input  logic                    resetn,
    // Instruction SRAM request and returned word
    output logic                    inst_sram_en,
    output logic [31:0]             inst_sram_addr,
    input  logic [31:0]             inst_sram_rdata,
    // Back from decode
    input  logic                    id_allowin,
    input  logic                    br_taken,
    input  logic [31:0]             br_target,
    // Forward to decode
    output logic                    if_to_id_valid,
    output frontend_pkg::if_to_id_t if_to_id
);

    logic        if_valid;
    logic        if_allowin;
    logic [31:0] if_pc;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;

    ////////////////////////////////////////////////////////////
    // Stage handshake
    ////////////////////////////////////////////////////////////

    // Word is ready as soon as SRAM returns it
    // Take a new word when empty or when decode drains this one
    assign if_allowin     = ~if_valid | id_allowin;
    assign if_to_id_valid = if_valid;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            if_valid <= 1'b0;
        end else if (if_allowin) begin
            // First request goes out in the cycle after reset
            if_valid <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // PC and next-PC select
    ////////////////////////////////////////////////////////////

    assign seq_pc  = if_pc + 32'd4;
    // Redirect wins over sequential
    assign next_pc = br_taken ? br_target : seq_pc;

    always_ff @(posedge clk) begin
        if (~resetn) begin
            // One word below boot so the first seq_pc is BOOT_PC
            if_pc <= `BOOT_PC - 32'd4;
        end else if (if_allowin) begin
            if_pc <= next_pc;
        end
    end

    // SRAM read only when the PC moves, otherwise rdata holds
    assign inst_sram_en   = if_allowin & resetn;
    assign inst_sram_addr = next_pc;

    // Word paired with the PC that fetched it
    always_comb begin
        if_to_id.pc   = if_pc;
        if_to_id.inst = inst_sram_rdata;
    end

endmodule

// ==== fetch/inst_sram.sv ====
`timescale 1ns/10ps
`include "frontend_defs.svh"

module inst_sram (
    input  logic                     clk,
    // Read port from fetch
    input  logic                     en,
    input  logic [`INST_SRAM_AW-1:0] addr,
    output logic [31:0]              rdata,
    // Program load, used while the core is in reset
    input  frontend_pkg::load_req_t  load
);

    // Word storage
    logic [31:0] mem [0:`INST_SRAM_DEPTH-1];

    ////////////////////////////////////////////////////////////
    // Write and registered read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load.en) begin
            // Load has priority, read skipped this cycle
            mem[load.addr] <= load.data;
        end else if (en) begin
            rdata <= mem[addr];
        end
        // No enable keeps the previous word on rdata
    end

endmodule

// ==== common/frontend_pkg.sv ====
`include "frontend_defs.svh"

package frontend_pkg;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    // Unconditional PC-relative branches, I26 format
    localparam logic [5:0] OP_B  = 6'b010100;
    localparam logic [5:0] OP_BL = 6'b010101;

    ////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////

    // I26 layout, offset split low half first
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    // 2RI12 layout, rd in the low bits
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    // Same 32 bits, decoded either way
    typedef union packed {
        fmt_i26_t   fmt_i26;
        fmt_2ri12_t fmt_2ri12;
    } inst_word_u;

    ////////////////////////////////////////////////////////////
    // Stage buses
    ////////////////////////////////////////////////////////////

    // Fetch to decode
    typedef struct packed {
        logic [31:0] pc;
        inst_word_u  inst;
    } if_to_id_t;

    // Decode to downstream
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        is_branch;
        logic [4:0]  rd;
    } id_to_ex_t;

    // Program load port, word addressed
    typedef struct packed {
        logic                     en;
        logic [`INST_SRAM_AW-1:0] addr;
        logic [31:0]              data;
    } load_req_t;

endpackage

// ==== common/frontend_defs.svh ====
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// First fetch address after reset
// PC register itself resets one word below this
`define BOOT_PC 32'h1C00_0000

// Instruction SRAM size in 32-bit words
`define INST_SRAM_DEPTH 256

// Word index width, must cover INST_SRAM_DEPTH
`define INST_SRAM_AW 8

`endif
